// File: src/cpu_cfg_pkg.sv
// CPU configuration package with the datapath width and register file sizes.
package cpu_cfg_pkg;

   // width of a data word and of every register.
   localparam int XLEN = 32;

   // register address width, five bits select one of the registers.
   localparam int REG_AW = 5;

   // number of architectural registers.
   // register 0 is hardwired to zero by the register file.
   localparam int NREG = 1 << REG_AW;

endpackage : cpu_cfg_pkg

// File: src/insn_pkg.sv
// Instruction package with the two field layouts, the decode union and the opcodes.
package insn_pkg;

   localparam int OPC_W  = 6;  // opcode field width.
   localparam int IMM_W  = 16; // immediate field width.
   localparam int FUNC_W = 11; // function field of the R-form.

   // opcodes at or above this value carry an immediate.
   localparam logic [OPC_W-1:0] OPC_IMM_BASE = 6'h20;

   // R-form opcodes.
   localparam logic [OPC_W-1:0] OPC_ADD  = 6'h01;
   localparam logic [OPC_W-1:0] OPC_SUB  = 6'h02;
   localparam logic [OPC_W-1:0] OPC_AND  = 6'h03;
   localparam logic [OPC_W-1:0] OPC_OR   = 6'h04;
   // I-form opcodes.
   localparam logic [OPC_W-1:0] OPC_ADDI = 6'h20;
   localparam logic [OPC_W-1:0] OPC_ANDI = 6'h21;
   localparam logic [OPC_W-1:0] OPC_LDI  = 6'h22;

   // two source registers, bits 31 down to 0.
   typedef struct packed {
      logic [OPC_W-1:0]               opc;  // 31:26.
      logic [cpu_cfg_pkg::REG_AW-1:0] rd;   // 25:21.
      logic [cpu_cfg_pkg::REG_AW-1:0] rs1;  // 20:16.
      logic [cpu_cfg_pkg::REG_AW-1:0] rs2;  // 15:11.
      logic [FUNC_W-1:0]              func; // 10:0.
   } insn_r_t;

   // one source register and a signed immediate.
   typedef struct packed {
      logic [OPC_W-1:0]               opc;  // 31:26.
      logic [cpu_cfg_pkg::REG_AW-1:0] rd;   // 25:21.
      logic [cpu_cfg_pkg::REG_AW-1:0] rs1;  // 20:16.
      logic [IMM_W-1:0]               imm;  // 15:0, sign bit at 15.
   } insn_i_t;

   // one instruction word seen through either layout.
   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_u;

endpackage : insn_pkg

// File: src/rf_port_if.sv
// Register file port bundle carrying two read ports and one write port.
`timescale 1ns/1ns

interface rf_port_if;

   import cpu_cfg_pkg::*;

   // read side, both ports share one enable.
   logic              re;
   logic [REG_AW-1:0] ra_a; // address of port A.
   logic [REG_AW-1:0] ra_b; // address of port B.
   logic [XLEN-1:0]   rd_a; // port A data, one cycle after re.
   logic [XLEN-1:0]   rd_b; // port B data, one cycle after re.

   // write side, one register per cycle.
   logic              we;
   logic [REG_AW-1:0] wa;
   logic [XLEN-1:0]   wd;

   // requester side, drives addresses and write data.
   modport master (
      output re, ra_a, ra_b,
      output we, wa, wd,
      input  rd_a, rd_b
   );

   // register file side.
   modport slave (
      input  re, ra_a, ra_b,
      input  we, wa, wd,
      output rd_a, rd_b
   );

endinterface : rf_port_if

// File: src/dpram_sclk.sv
// Single-clock dual-port RAM cell with registered read, write bypass and gated output.
`timescale 1ns/1ns

module dpram_sclk #(
   parameter int AW            = 5,
   parameter int DW            = 32,
   parameter bit CLEAR_ON_INIT = 1'b1,
   parameter bit ENABLE_BYPASS = 1'b1
) (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  logic [AW-1:0] raddr,
   input  logic          re,
   input  logic [AW-1:0] waddr,
   input  logic          we,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout
);

   localparam int DEPTH = 1 << AW; // words in the array.

   logic [DW-1:0] mem [DEPTH];
   logic [DW-1:0] mem_q;  // word read from the array.
   logic [DW-1:0] data_w; // array word or bypassed write data.
   logic          re_q;   // read enable seen last cycle.

   // start from an all-zero array.
   generate
      if (CLEAR_ON_INIT) begin : g_clear
         initial begin
            for (int i = 0; i < DEPTH; i++) begin
               mem[i] = '0;
            end
         end
      end
   endgenerate

   // write and registered read.
   always @(posedge clk_i) begin
      if (we) begin
         mem[waddr] <= din;
      end
      if (re) begin
         mem_q <= mem[raddr]; // old contents on a same-address write.
      end
   end

   generate
      if (ENABLE_BYPASS) begin : g_bypass
         logic [DW-1:0] din_q; // write data captured with the read.
         logic          hit_q; // read and write met on one address.

         always_ff @(posedge clk_i) begin
            if (re) begin
               din_q <= din;
            end
         end

         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               hit_q <= 1'b0;
            end else begin
               hit_q <= re && we && (raddr == waddr);
            end
         end

         assign data_w = hit_q ? din_q : mem_q; // new data wins on a hit.
      end else begin : g_no_bypass
         assign data_w = mem_q;
      end
   endgenerate

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         re_q <= 1'b0;
      end else begin
         re_q <= re;
      end
   end

   assign dout = re_q ? data_w : '0; // zero unless a read was issued.

endmodule : dpram_sclk

// File: src/regfile.sv
// Register file with two read ports and one write port built from two RAM cells.
`timescale 1ns/1ns

module regfile (
   input logic      clk_i,
   input logic      rst_n_i,
   rf_port_if.slave rf
);

   import cpu_cfg_pkg::*;

   logic            wr_en;    // write enable with register 0 masked off.
   logic [XLEN-1:0] cell_a;   // raw data of the port A cell.
   logic [XLEN-1:0] cell_b;   // raw data of the port B cell.
   logic            zero_a_q; // port A read register 0.
   logic            zero_b_q; // port B read register 0.

   // register 0 is never written.
   assign wr_en = rf.we && (rf.wa != '0);

   // each cell takes every write and keeps a full copy.
   dpram_sclk #(
      .AW           (REG_AW),
      .DW           (XLEN),
      .CLEAR_ON_INIT(1'b1),
      .ENABLE_BYPASS(1'b1)
   ) i_cell_a (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .raddr  (rf.ra_a),
      .re     (rf.re),
      .waddr  (rf.wa),
      .we     (wr_en),
      .din    (rf.wd),
      .dout   (cell_a)
   );

   dpram_sclk #(
      .AW           (REG_AW),
      .DW           (XLEN),
      .CLEAR_ON_INIT(1'b1),
      .ENABLE_BYPASS(1'b1)
   ) i_cell_b (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .raddr  (rf.ra_b),
      .re     (rf.re),
      .waddr  (rf.wa),
      .we     (wr_en),
      .din    (rf.wd),
      .dout   (cell_b)
   );

   // remember a register 0 read for the next cycle.
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         zero_a_q <= 1'b0;
         zero_b_q <= 1'b0;
      end else begin
         zero_a_q <= (rf.ra_a == '0);
         zero_b_q <= (rf.ra_b == '0);
      end
   end

   assign rf.rd_a = zero_a_q ? '0 : cell_a; // register 0 reads zero.
   assign rf.rd_b = zero_b_q ? '0 : cell_b;

endmodule : regfile

// File: src/operand_fetch.sv
// Operand fetch stage that decodes the issued word, reads the registers and forms A and B.
`timescale 1ns/1ns

module operand_fetch (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           issue_valid,
   input  insn_pkg::insn_u                issue_insn,
   input  logic                           wb_we,
   input  logic [cpu_cfg_pkg::REG_AW-1:0] wb_rd,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   wb_data,
   output logic                           op_valid,
   output logic [cpu_cfg_pkg::XLEN-1:0]   op_b,
   output logic [cpu_cfg_pkg::XLEN-1:0]   op_a,
   output logic [cpu_cfg_pkg::REG_AW-1:0] op_rd,
   output logic                           op_imm,
   rf_port_if.master                      rf
);

   import cpu_cfg_pkg::*;
   import insn_pkg::*;

   // decoded fields of the issued word.
   logic [OPC_W-1:0]  opc;
   logic [REG_AW-1:0] rs1;
   logic [REG_AW-1:0] rs2;
   logic [IMM_W-1:0]  imm;
   logic              is_imm;  // word is I-form.
   logic [XLEN-1:0]   imm_ext; // immediate widened with its sign.

   // fields held alongside the RAM read.
   logic              valid_q;
   logic              imm_form_q; // held I-form flag, only set for a valid issue.
   logic [XLEN-1:0]   imm_q;
   logic [REG_AW-1:0] rd_q;

   // the R view gives the register fields, the I view the immediate.
   assign opc = issue_insn.r.opc;
   assign rs1 = issue_insn.r.rs1; // same bits in both forms.
   assign rs2 = issue_insn.r.rs2;
   assign imm = issue_insn.i.imm;

   assign is_imm  = (opc >= OPC_IMM_BASE);
   assign imm_ext = {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm};

   // read request, one per issued word.
   assign rf.re   = issue_valid;
   assign rf.ra_a = rs1;
   assign rf.ra_b = is_imm ? '0 : rs2; // I-form leaves port B on register 0.

   // write-back goes straight to the register file.
   assign rf.we = wb_we;
   assign rf.wa = wb_rd;
   assign rf.wd = wb_data;

   // control flags.
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q    <= 1'b0;
         imm_form_q <= 1'b0;
      end else begin
         valid_q    <= issue_valid;
         imm_form_q <= issue_valid && is_imm; // low on empty cycles keeps op_b zero.
      end
   end

   // payload, loaded with each issue.
   always_ff @(posedge clk_i) begin
      if (issue_valid) begin
         rd_q  <= issue_insn.r.rd;
         imm_q <= imm_ext;
      end
   end

   // operands line up with the RAM data.
   assign op_valid = valid_q;
   assign op_a     = rf.rd_a;
   assign op_b     = imm_form_q ? imm_q : rf.rd_b; // immediate replaces rs2.
   assign op_rd    = rd_q;
   assign op_imm   = imm_form_q;

endmodule : operand_fetch

// File: src/opf_top.sv
// Operand fetch top level joining the fetch stage and the register file on plain ports.
`timescale 1ns/1ns

module opf_top (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   // issue side.
   input  logic                           issue_valid,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   issue_insn,
   // write-back side.
   input  logic                           wb_we,
   input  logic [cpu_cfg_pkg::REG_AW-1:0] wb_rd,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   wb_data,
   // operands, one cycle after issue.
   output logic                           op_valid,
   output logic [cpu_cfg_pkg::XLEN-1:0]   op_a,
   output logic [cpu_cfg_pkg::XLEN-1:0]   op_b,
   output logic [cpu_cfg_pkg::REG_AW-1:0] op_rd,
   output logic                           op_imm
);

   rf_port_if i_rf_if (); // read and write ports of the register file.

   // decode and operand forming.
   operand_fetch i_operand_fetch (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .issue_valid(issue_valid),
      .issue_insn (issue_insn), // raw word seen as the decode union.
      .wb_we      (wb_we),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data),
      .op_valid   (op_valid),
      .op_b       (op_b),
      .op_a       (op_a),
      .op_rd      (op_rd),
      .op_imm     (op_imm),
      .rf         (i_rf_if.master)
   );

   // two cells, register 0 held at zero.
   regfile i_regfile (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .rf     (i_rf_if.slave)
   );

endmodule : opf_top

// File: test/opf_top_chk.sv
// Operand fetch port checker with concurrent assertions bound into the top level.
`timescale 1ns/1ns

module opf_top_chk (
   input logic                         clk_i,
   input logic                         rst_n_i,
   input logic                         issue_valid,
   input logic                         op_valid,
   input logic [cpu_cfg_pkg::XLEN-1:0] op_a,
   input logic [cpu_cfg_pkg::XLEN-1:0] op_b
);

   // first edge out of reset sees no result.
   a_idle_after_reset : assert property (@(posedge clk_i) $rose(rst_n_i) |-> !op_valid)
      else $error("op_valid was high in the first cycle after reset");

   // fixed one-cycle latency, one result per issue.
   a_valid_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      op_valid == $past(issue_valid))
      else $error("op_valid did not follow issue_valid by one cycle");

   // gated read outputs on empty cycles.
   a_zero_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !op_valid |-> (op_a == '0 && op_b == '0))
      else $error("op_a or op_b not zero while op_valid was low");

endmodule : opf_top_chk

// attach to every opf_top instance.
bind opf_top opf_top_chk i_opf_top_chk (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .issue_valid(issue_valid),
   .op_valid   (op_valid),
   .op_a       (op_a),
   .op_b       (op_b)
);

// File: test/opf_monitor.sv
// Operand fetch monitor with a shadow register model that checks every result.
`timescale 1ns/1ns

module opf_monitor (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           issue_valid,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   issue_insn,
   input  logic                           wb_we,
   input  logic [cpu_cfg_pkg::REG_AW-1:0] wb_rd,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   wb_data,
   input  logic                           op_valid,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   op_a,
   input  logic [cpu_cfg_pkg::XLEN-1:0]   op_b,
   input  logic [cpu_cfg_pkg::REG_AW-1:0] op_rd,
   input  logic                           op_imm,
   output int                             err_cnt,
   output int                             chk_cnt
);

   import cpu_cfg_pkg::*;
   import insn_pkg::*;

   logic [XLEN-1:0]   regs [NREG]; // shadow register contents.
   insn_u             insn;        // issued word seen through both views.
   logic              is_i;        // I-form by opcode range.
   logic              exp_valid;   // a result is due this cycle.
   logic [XLEN-1:0]   exp_a;
   logic [XLEN-1:0]   exp_b;
   logic [REG_AW-1:0] exp_rd;
   logic              exp_imm;

   assign insn = issue_insn;
   assign is_i = (insn.i.opc >= OPC_IMM_BASE);

   // register value seen by a read in this cycle with a same-cycle write forwarded.
   function automatic logic [XLEN-1:0] src_value(input logic [REG_AW-1:0] addr);
      if (addr == '0) return '0; // register 0 is always zero.
      if (wb_we && wb_rd == addr) return wb_data;
      return regs[addr];
   endfunction

   // immediate taken as a signed number and widened to a full operand.
   function automatic logic [XLEN-1:0] sext_imm(input logic signed [IMM_W-1:0] imm);
      logic signed [XLEN-1:0] wide;
      wide = imm; // signed widening repeats the sign bit.
      return wide;
   endfunction

   task automatic check_field(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error: %s got %h expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   initial begin
      err_cnt = 0;
      chk_cnt = 0;
      for (int i = 0; i < NREG; i++) begin
         regs[i] = '0; // registers start cleared.
      end
   end

   // expected result is formed at the edge that ends the issue cycle.
   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exp_valid <= 1'b0;
      end else begin
         exp_valid <= issue_valid;
         if (issue_valid) begin
            exp_a   <= src_value(insn.i.rs1);
            exp_b   <= is_i ? sext_imm(insn.i.imm) : src_value(insn.r.rs2);
            exp_rd  <= insn.i.rd;
            exp_imm <= is_i;
         end
         if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data; // writes to register 0 dropped.
         end
      end
   end

   // outputs are settled mid-cycle.
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         check_field("op_valid", 32'(op_valid), 32'(exp_valid));
         if (exp_valid) begin
            check_field("op_a", op_a, exp_a);
            check_field("op_b", op_b, exp_b);
            check_field("op_rd", 32'(op_rd), 32'(exp_rd));
            check_field("op_imm", 32'(op_imm), 32'(exp_imm));
         end else begin
            check_field("op_a", op_a, '0); // idle cycles read zero.
            check_field("op_b", op_b, '0);
         end
      end
   end

endmodule : opf_monitor

// File: test/tb_opf_top.sv
// Operand fetch testbench driving directed and random rows through the top level.
`timescale 1ns/1ns

module tb_opf_top;

   import cpu_cfg_pkg::*;
   import insn_pkg::*;

   localparam int N_RAND = 200;        // random rows after the directed ones.
   localparam logic [31:0] SEED = 32'd34060;

   // one table row, applied for one cycle.
   typedef struct packed {
      logic              vld;
      logic [OPC_W-1:0]  opc;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic [IMM_W-1:0]  imm;
      logic              we;
      logic [REG_AW-1:0] wrd;
      logic [XLEN-1:0]   wdata;
   } row_t;

   logic              clk_i, rst_n_i;
   logic              issue_valid, wb_we;
   logic [XLEN-1:0]   issue_insn, wb_data;
   logic [REG_AW-1:0] wb_rd, op_rd;
   logic              op_valid, op_imm;
   logic [XLEN-1:0]   op_a, op_b;
   int                err_cnt, chk_cnt;
   row_t              tbl [$];
   logic              tbl_ready = 1'b0;
   logic [31:0]       lcg_state = SEED;

   opf_top i_opf_top (.*);

   opf_monitor i_monitor (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // upper half of the LCG state, low bits are weak.
   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];
   endfunction

   task automatic add_row(input logic vld, input logic [OPC_W-1:0] opc,
                          input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
                          input logic [REG_AW-1:0] rs2, input logic [IMM_W-1:0] imm,
                          input logic we, input logic [REG_AW-1:0] wrd,
                          input logic [XLEN-1:0] wdata);
      tbl.push_back('{vld, opc, rd, rs1, rs2, imm, we, wrd, wdata});
   endtask

   // packs the row fields into the layout its opcode selects.
   function automatic logic [XLEN-1:0] make_insn(input row_t r);
      insn_u u;
      if (r.opc >= OPC_IMM_BASE) begin
         u.i.opc = r.opc;
         u.i.rd  = r.rd;
         u.i.rs1 = r.rs1;
         u.i.imm = r.imm;
      end else begin
         u.r.opc  = r.opc;
         u.r.rd   = r.rd;
         u.r.rs1  = r.rs1;
         u.r.rs2  = r.rs2;
         u.r.func = '0;
      end
      return u;
   endfunction

   task automatic build_table();
      logic [15:0] r;
      // vld opc rd rs1 rs2 imm we wrd wdata.
      add_row(1, OPC_ADD, 5'd3, 5'd1, 5'd31, 16'h0, 0, 5'd0, 32'h0);            // cleared regs.
      add_row(0, OPC_ADD, 5'd0, 5'd0, 5'd0, 16'h0, 1, 5'd1, 32'h1111_1111);
      add_row(1, OPC_SUB, 5'd4, 5'd1, 5'd2, 16'h0, 1, 5'd2, 32'ha5a5_0002);     // bypass on rs2.
      add_row(1, OPC_ADDI, 5'd5, 5'd2, 5'd0, 16'h8001, 0, 5'd0, 32'h0);        // negative imm.
      add_row(1, OPC_LDI, 5'd6, 5'd0, 5'd0, 16'h7fff, 1, 5'd6, 32'h0bad_f00d);
      add_row(1, OPC_AND, 5'd7, 5'd0, 5'd0, 16'h0, 1, 5'd0, 32'hdead_beef);     // r0 write.
      add_row(1, OPC_OR, 5'd8, 5'd0, 5'd6, 16'h0, 0, 5'd0, 32'h0);
      add_row(1, OPC_ANDI, 5'd9, 5'd6, 5'd0, 16'h1234, 1, 5'd6, 32'h6666_0006); // bypass on rs1.
      add_row(0, OPC_ADD, 5'd0, 5'd0, 5'd0, 16'h0, 0, 5'd0, 32'h0);
      for (int k = 0; k < N_RAND; k++) begin
         r = next_rand();
         // small register range so reads and writes collide often.
         add_row(r[15] | r[14],
                 r[13] ? (OPC_IMM_BASE | {4'h0, r[12:11]}) : {4'h0, r[12:11]},
                 r[10:6], {2'b00, r[5:3]}, {2'b00, r[2:0]}, next_rand(),
                 r[1] | r[0], {2'b00, r[8:6]}, {next_rand(), next_rand()});
      end
   endtask

   initial begin
      row_t row;
      rst_n_i     = 1'b0;
      issue_valid = 1'b0;
      issue_insn  = '0;
      wb_we       = 1'b0;
      wb_rd       = '0;
      wb_data     = '0;
      build_table();
      tbl_ready = 1'b1;
      repeat (2) @(posedge clk_i);
      #1 rst_n_i = 1'b1;
      foreach (tbl[k]) begin
         row = tbl[k];
         @(posedge clk_i);
         #1;
         issue_valid = row.vld;
         issue_insn  = make_insn(row);
         wb_we       = row.we;
         wb_rd       = row.wrd;
         wb_data     = row.wdata;
      end
      @(posedge clk_i);
      #1;
      issue_valid = 1'b0; // drain the last result.
      wb_we       = 1'b0;
      repeat (3) @(posedge clk_i);
      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // watchdog, 20 periods per table row plus margin.
   initial begin
      wait (tbl_ready);
      #((20 * tbl.size() + 50) * 10);
      $display("watchdog expired before the table finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule : tb_opf_top

// File: tb.f
src/cpu_cfg_pkg.sv
src/insn_pkg.sv
src/rf_port_if.sv
src/dpram_sclk.sv
src/regfile.sv
src/operand_fetch.sv
src/opf_top.sv
test/opf_top_chk.sv
test/opf_monitor.sv
test/tb_opf_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the operand fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module tb_opf_top \
   --Mdir "$OBJ" -o sim_tb \
   -f tb.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "result: fail"
   exit 1
fi

echo "result: pass"
exit 0
